// ==== logic/accel_regs_pkg.sv ====
package accel_regs_pkg;

  // --------------------
  // bus widths and types
  // --------------------

  localparam int BUS_ADDR_W = 20;            // decoded address bits
  localparam int BUS_DATA_W = 32;

  typedef logic [BUS_DATA_W-1:0] bus_word_t; // bus data word
  typedef logic [BUS_ADDR_W-1:0] bus_addr_t; // decoded byte address

  // --------------------
  // register map
  // --------------------

  // global section
  localparam bus_addr_t ADDR_CTRL        = 20'h00000;  // global control, r/w
  localparam bus_addr_t ADDR_STATUS      = 20'h00004;  // global status, ro
  localparam bus_addr_t ADDR_VERSION     = 20'h0000C;  // version word, ro

  // hash unit section
  localparam bus_addr_t ADDR_HASH_CTRL   = 20'h00100;  // unit control, r/w
  localparam bus_addr_t ADDR_HASH_STATUS = 20'h00104;  // unit and fifo status, ro
  localparam bus_addr_t ADDR_FIFO_PUSH   = 20'h0010C;  // wr pushes, rd gives fill level
  localparam bus_addr_t ADDR_HASH_H7     = 20'h00110;  // least significant hash word
  localparam bus_addr_t ADDR_HASH_H0     = 20'h0012C;  // most significant hash word
  localparam bus_addr_t ADDR_FIFO_COUNT  = 20'h00130;  // fill level, ro

  // --------------------
  // control bit positions
  // --------------------

  localparam int CTRL_ENABLE    = 0;  // global enable

  localparam int HCTRL_ENABLE   = 0;  // hash unit enable
  localparam int HCTRL_RESET    = 1;  // one-shot, self clearing
  localparam int HCTRL_DBL_HASH = 4;  // hash of the hash

  // build stamp, YYMMDDss
  localparam bus_word_t VERSION_WORD = 32'h00010101;

  // request from the bus master, held for one cycle per access
  typedef struct packed {
    bus_addr_t addr;
    bus_word_t wdata;
    logic      wen;
    logic      ren;
  } bus_req_t;

  // response, ack one cycle after the request
  typedef struct packed {
    bus_word_t rdata;
    logic      ack;
  } bus_rsp_t;

endpackage

// ==== logic/hash_pkg.sv ====
package hash_pkg;

  // --------------------
  // widths
  // --------------------

  localparam int DATA_W     = 32;                     // fifo and hash word width
  localparam int HASH_WORDS = 8;                      // H0..H7
  localparam int HASH_IDX_W = $clog2(HASH_WORDS);     // selects one hash word

  localparam int FIFO_DEPTH = 512;                    // power of two, pointers wrap
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = FIFO_AW + 1;            // 0 .. FIFO_DEPTH inclusive

  typedef logic [HASH_WORDS*DATA_W-1:0] hash_t;      // H0 in the top word
  typedef logic [FIFO_CNT_W-1:0]        fifo_cnt_t;
  typedef logic [DATA_W-1:0]            data_word_t;

  // --------------------
  // engine port
  // --------------------

  // towards the hash core
  typedef struct packed {
    logic       rstn;      // unit reset, active low
    logic       start;     // one cycle pulse
    logic       dbl_hash;  // level, gated with rstn
    logic       rd_vld;    // fifo read data valid
    data_word_t rd_data;
    logic       empty;     // fifo empty
  } eng_req_t;

  // from the hash core
  typedef struct packed {
    logic  ready;       // level
    logic  rd_en;       // one cycle pop, only while not empty
    logic  hash_valid;  // level, rising edge marks a new hash
    hash_t hash;
  } eng_rsp_t;

endpackage

// ==== logic/bus_regs.sv ====
module bus_regs
  import accel_regs_pkg::*;
  import hash_pkg::*;
(
  input  logic       bus_clk,
  input  logic       bus_rstn,

  input  bus_req_t   bus_req_i,
  output bus_rsp_t   bus_rsp_o,

  output logic       x11_enable_o,      // global enable
  output logic       hash_enable_o,
  output logic       hash_soft_reset_o, // one cycle pulse
  output logic       dbl_hash_o,
  output logic       push_en_o,         // one cycle fifo write strobe
  output data_word_t push_data_o,

  input  bus_word_t  unit_status_i,
  input  bus_word_t  hash_status_i,
  input  hash_t      hash_i,
  input  fifo_cnt_t  fill_i
);

  bus_word_t  ctrl_q;       // global control
  bus_word_t  hctrl_q;      // hash unit control
  logic       push_en_q;
  data_word_t push_data_q;

  bus_word_t  rd_mux;
  bus_word_t  rdata_q;
  logic       ack_q;

  bus_addr_t              hash_ofs;  // offset into the hash window
  logic [HASH_IDX_W-1:0]  hash_idx;
  logic                   hash_hit;

  // --------------------
  // write side
  // --------------------

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      ctrl_q    <= '0;
      hctrl_q   <= '0;
      push_en_q <= 1'b0;
    end else begin
      hctrl_q[HCTRL_RESET] <= 1'b0;  // one-shot, gone next cycle
      push_en_q            <= 1'b0;
      if (bus_req_i.wen) begin
        case (bus_req_i.addr)
          ADDR_CTRL:      ctrl_q    <= bus_req_i.wdata;
          ADDR_HASH_CTRL: hctrl_q   <= bus_req_i.wdata;  // overrides the clear above
          ADDR_FIFO_PUSH: push_en_q <= 1'b1;
          default: ;                                      // read only or unmapped
        endcase
      end
    end
  end

  // push payload, only meaningful with the strobe
  always_ff @(posedge bus_clk) begin
    if (bus_req_i.wen && bus_req_i.addr == ADDR_FIFO_PUSH) begin
      push_data_q <= bus_req_i.wdata;
    end
  end

  assign x11_enable_o      = ctrl_q[CTRL_ENABLE];
  assign hash_enable_o     = hctrl_q[HCTRL_ENABLE];
  assign hash_soft_reset_o = hctrl_q[HCTRL_RESET];
  assign dbl_hash_o        = hctrl_q[HCTRL_DBL_HASH];
  assign push_en_o         = push_en_q;
  assign push_data_o       = push_data_q;

  // --------------------
  // read side
  // --------------------

  // hash window 0x110..0x12C, H7 at the bottom
  assign hash_ofs = bus_req_i.addr - ADDR_HASH_H7;
  assign hash_idx = hash_ofs[2 +: HASH_IDX_W];   // word index, 0 = H7 = lsw
  assign hash_hit = (bus_req_i.addr >= ADDR_HASH_H7) &&
                    (bus_req_i.addr <= ADDR_HASH_H0) &&
                    (bus_req_i.addr[1:0] == 2'b00);

  always_comb begin
    rd_mux = '0;  // unmapped reads as zero
    case (bus_req_i.addr)
      ADDR_CTRL:        rd_mux = ctrl_q;
      ADDR_STATUS:      rd_mux = unit_status_i;
      ADDR_VERSION:     rd_mux = VERSION_WORD;
      ADDR_HASH_CTRL:   rd_mux = hctrl_q;
      ADDR_HASH_STATUS: rd_mux = hash_status_i;
      ADDR_FIFO_PUSH,
      ADDR_FIFO_COUNT:  rd_mux = bus_word_t'(fill_i);  // zero extended
      default: begin
        if (hash_hit) begin
          rd_mux = hash_i[hash_idx*DATA_W +: DATA_W];
        end
      end
    endcase
  end

  // ack on every access, reads and writes alike
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req_i.ren | bus_req_i.wen;
    end
  end

  // rdata only carries data next to a read ack
  always_ff @(posedge bus_clk) begin
    rdata_q <= bus_req_i.ren ? rd_mux : '0;
  end

  assign bus_rsp_o.rdata = rdata_q;
  assign bus_rsp_o.ack   = ack_q;

endmodule

// ==== logic/hash_unit_ctrl.sv ====
module hash_unit_ctrl
  import accel_regs_pkg::*;
  import hash_pkg::*;
(
  input  logic      bus_clk,
  input  logic      bus_rstn,

  input  logic      x11_enable_i,       // global enable
  input  logic      hash_enable_i,
  input  logic      hash_soft_reset_i,  // one cycle pulse
  input  logic      dbl_hash_i,

  input  logic      fifo_empty_i,
  input  logic      fifo_almost_full_i,
  input  logic      fifo_full_i,

  input  logic      eng_ready_i,
  input  logic      hash_valid_i,
  input  hash_t     hash_i,

  output logic      unit_rstn_o,
  output logic      start_o,
  output logic      dbl_hash_o,
  output hash_t     hash_o,
  output bus_word_t unit_status_o,
  output bus_word_t hash_status_o
);

  logic  unit_rstn_q;
  logic  start_q;
  logic  hash_valid_d;  // for edge detect
  hash_t hash_q;

  // --------------------
  // unit activation
  // --------------------

  // held low until both enables are up, dropped by a soft reset pulse
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      unit_rstn_q <= 1'b0;
    end else begin
      unit_rstn_q <= x11_enable_i & hash_enable_i & ~hash_soft_reset_i;
    end
  end

  // --------------------
  // start pulse
  // --------------------

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || !unit_rstn_q) begin
      start_q <= 1'b0;
    end else begin
      // single cycle even when ready stays high
      start_q <= eng_ready_i & ~fifo_empty_i & ~start_q;
    end
  end

  // --------------------
  // hash capture
  // --------------------

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || !unit_rstn_q) begin
      hash_valid_d <= 1'b0;
      hash_q       <= '0;      // hash regs read zero while the unit is down
    end else begin
      hash_valid_d <= hash_valid_i;
      if (hash_valid_i && !hash_valid_d) begin
        hash_q <= hash_i;      // new hash on the rising edge only
      end
    end
  end

  assign unit_rstn_o = unit_rstn_q;
  assign start_o     = start_q;
  assign dbl_hash_o  = dbl_hash_i & unit_rstn_q;  // core sees it only when active
  assign hash_o      = hash_q;

  // status words
  assign unit_status_o = {27'b0, unit_rstn_q, 3'b0, x11_enable_i};
  assign hash_status_o = {25'b0,
                          fifo_full_i,         // bit 6
                          fifo_almost_full_i,  // bit 5
                          fifo_empty_i,        // bit 4
                          2'b0,
                          hash_valid_i,        // bit 1
                          eng_ready_i};        // bit 0

endmodule

// ==== logic/word_fifo.sv ====
module word_fifo
  import hash_pkg::*;
(
  input  logic       bus_clk,
  input  logic       bus_rstn,
  input  logic       clr_n_i,        // unit reset, clears contents

  input  logic       wr_en_i,
  input  data_word_t wr_data_i,

  input  logic       rd_en_i,
  output data_word_t rd_data_o,      // valid the cycle after rd_en
  output logic       rd_vld_o,

  output logic       empty_o,
  output logic       almost_full_o,  // one slot left
  output logic       full_o,
  output fifo_cnt_t  fill_o
);

  data_word_t         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  fifo_cnt_t          fill_q;
  data_word_t         rd_data_q;
  logic               rd_vld_q;

  logic do_wr;  // accepted push
  logic do_rd;  // accepted pop

  assign do_wr = wr_en_i & ~full_o;   // push on full is dropped
  assign do_rd = rd_en_i & ~empty_o;  // pop on empty is ignored

  // --------------------
  // pointers and level
  // --------------------

  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || !clr_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_q   <= '0;
      rd_vld_q <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // wraps at FIFO_DEPTH
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: ;                        // both or none, level unchanged
      endcase
      rd_vld_q <= do_rd;
    end
  end

  // --------------------
  // storage
  // --------------------

  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (do_rd) begin
      rd_data_q <= mem[rd_ptr];  // registered read
    end
  end

  // flags follow the registered level
  assign empty_o       = (fill_q == '0);
  assign full_o        = (fill_q == fifo_cnt_t'(FIFO_DEPTH));
  assign almost_full_o = (fill_q == fifo_cnt_t'(FIFO_DEPTH - 1));
  assign fill_o        = fill_q;
  assign rd_data_o     = rd_data_q;
  assign rd_vld_o      = rd_vld_q;

endmodule

// ==== logic/hash_accel_regs.sv ====
module hash_accel_regs
  import accel_regs_pkg::*;
  import hash_pkg::*;
(
  input  logic     bus_clk,
  input  logic     bus_rstn,

  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,

  input  eng_rsp_t eng_rsp_i,    // from the hash core
  output eng_req_t eng_req_o,    // to the hash core

  output logic     activated_o   // global enable
);

  // bus_regs -> unit ctrl / fifo
  logic       x11_enable;
  logic       hash_enable;
  logic       hash_soft_reset;
  logic       dbl_hash_lvl;      // raw control bit
  logic       push_en;
  data_word_t push_data;

  // unit ctrl / fifo -> bus_regs
  bus_word_t  unit_status;
  bus_word_t  hash_status;
  hash_t      hash_regs;
  fifo_cnt_t  fill;

  // engine side
  logic       unit_rstn;
  logic       start;
  logic       dbl_hash_gated;
  data_word_t fifo_rd_data;
  logic       fifo_rd_vld;
  logic       fifo_empty;
  logic       fifo_almost_full;
  logic       fifo_full;

  bus_regs u_bus_regs (
    .bus_clk           (bus_clk),
    .bus_rstn          (bus_rstn),
    .bus_req_i         (bus_req_i),
    .bus_rsp_o         (bus_rsp_o),
    .x11_enable_o      (x11_enable),
    .hash_enable_o     (hash_enable),
    .hash_soft_reset_o (hash_soft_reset),
    .dbl_hash_o        (dbl_hash_lvl),
    .push_en_o         (push_en),
    .push_data_o       (push_data),
    .unit_status_i     (unit_status),
    .hash_status_i     (hash_status),
    .hash_i            (hash_regs),
    .fill_i            (fill)
  );

  hash_unit_ctrl u_hash_unit_ctrl (
    .bus_clk            (bus_clk),
    .bus_rstn           (bus_rstn),
    .x11_enable_i       (x11_enable),
    .hash_enable_i      (hash_enable),
    .hash_soft_reset_i  (hash_soft_reset),
    .dbl_hash_i         (dbl_hash_lvl),
    .fifo_empty_i       (fifo_empty),
    .fifo_almost_full_i (fifo_almost_full),
    .fifo_full_i        (fifo_full),
    .eng_ready_i        (eng_rsp_i.ready),
    .hash_valid_i       (eng_rsp_i.hash_valid),
    .hash_i             (eng_rsp_i.hash),
    .unit_rstn_o        (unit_rstn),
    .start_o            (start),
    .dbl_hash_o         (dbl_hash_gated),
    .hash_o             (hash_regs),
    .unit_status_o      (unit_status),
    .hash_status_o      (hash_status)
  );

  // read side popped directly by the core
  word_fifo u_word_fifo (
    .bus_clk       (bus_clk),
    .bus_rstn      (bus_rstn),
    .clr_n_i       (unit_rstn),
    .wr_en_i       (push_en),
    .wr_data_i     (push_data),
    .rd_en_i       (eng_rsp_i.rd_en),
    .rd_data_o     (fifo_rd_data),
    .rd_vld_o      (fifo_rd_vld),
    .empty_o       (fifo_empty),
    .almost_full_o (fifo_almost_full),
    .full_o        (fifo_full),
    .fill_o        (fill)
  );

  assign eng_req_o = '{rstn:     unit_rstn,
                       start:    start,
                       dbl_hash: dbl_hash_gated,
                       rd_vld:   fifo_rd_vld,
                       rd_data:  fifo_rd_data,
                       empty:    fifo_empty};

  assign activated_o = x11_enable;

endmodule

// ==== testbench/tb_tasks.svh ====
// --------------------
// helpers
// --------------------

// every task starts and ends DRV_DLY after a rising edge
task automatic next_cycle();
  @(posedge bus_clk);
  #DRV_DLY;
endtask

task automatic check_word(input bus_word_t got, input bus_word_t exp, input string what);
  assert (got === exp) else begin
    abort_run($sformatf("CHECK FAILED at %0t: %s, got %h expected %h",
                        $time, what, got, exp));
  end
endtask

task automatic bus_write(input bus_addr_t addr, input bus_word_t data);
  bus_req.addr  = addr;
  bus_req.wdata = data;
  bus_req.wen   = 1'b1;
  next_cycle();
  bus_req.wen   = 1'b0;
  check_word(bus_word_t'(bus_rsp.ack), 32'd1, $sformatf("write to %h not acked", addr));
endtask

task automatic bus_read(input bus_addr_t addr, output bus_word_t data);
  bus_req.addr = addr;
  bus_req.ren  = 1'b1;
  next_cycle();
  bus_req.ren  = 1'b0;
  check_word(bus_word_t'(bus_rsp.ack), 32'd1, $sformatf("read of %h not acked", addr));
  data = bus_rsp.rdata;
endtask

function automatic logic req_level(input string sig);
  return (sig == "rstn") ? eng_req.rstn : eng_req.dbl_hash;
endfunction

task automatic wait_req_level(input string sig, input logic val);
  int cnt = 0;
  while (req_level(sig) !== val && cnt < WAIT_LIMIT) begin
    next_cycle();
    cnt++;
  end
  if (req_level(sig) !== val) begin
    abort_run($sformatf("timeout: eng_req_o.%s never became %0b", sig, val));
  end
endtask

task automatic wait_popped(input int n);
  int cnt = 0;
  while (popped.size() < n && cnt < WAIT_LIMIT) begin
    next_cycle();
    cnt++;
  end
  if (popped.size() < n) begin
    abort_run($sformatf("timeout: engine popped %0d words, expected %0d", popped.size(), n));
  end
endtask

task automatic wait_start();
  int cnt = 0;
  while (start_cnt == 0 && cnt < WAIT_LIMIT) begin
    next_cycle();
    cnt++;
  end
  if (start_cnt == 0) abort_run("timeout: the unit never pulsed start");
endtask

// polls the fill level over the bus
task automatic wait_fill(input int unsigned n);
  bus_word_t v;
  int        cnt;
  cnt = 0;
  bus_read(ADDR_FIFO_COUNT, v);
  while (v !== n && cnt < WAIT_LIMIT) begin
    bus_read(ADDR_FIFO_COUNT, v);
    cnt++;
  end
  if (v !== n) abort_run($sformatf("timeout: fill level stuck at %0d, wanted %0d", v, n));
endtask

task automatic push_words(input int n, input data_word_t base);
  data_word_t w;
  for (int i = 0; i < n; i++) begin
    w = base + data_word_t'(i);
    bus_write(ADDR_FIFO_PUSH, w);
    if (i < FIFO_DEPTH) pushed.push_back(w);  // beyond depth is dropped
  end
endtask

task automatic enable_unit();
  bus_write(ADDR_CTRL, CTRL_ON);
  bus_write(ADDR_HASH_CTRL, HCTRL_ON);
  wait_req_level("rstn", 1'b1);
endtask

// --------------------
// directed tests
// --------------------

task automatic test_reset_version();
  bus_word_t v;
  bus_read(ADDR_CTRL, v);
  check_word(v, '0, "CTRL after reset");
  bus_read(ADDR_HASH_CTRL, v);
  check_word(v, '0, "HASH_CTRL after reset");
  bus_read(ADDR_STATUS, v);
  check_word(v, '0, "STATUS after reset");
  bus_read(ADDR_HASH_STATUS, v);
  check_word(v, HST_EMPTY, "HASH_STATUS after reset");  // only empty
  bus_read(ADDR_VERSION, v);
  check_word(v, VERSION_WORD, "version word");
  bus_read(20'h00008, v);
  check_word(v, '0, "unmapped read at 0x008");
  bus_read(20'h00200, v);
  check_word(v, '0, "unmapped read at 0x200");
  bus_write(20'h00300, 32'hFFFF_FFFF);  // unmapped write, still acked
  next_cycle();
  check_word(bus_word_t'(bus_rsp.ack), '0, "ack longer than one cycle");
  check_word(bus_word_t'(activated), '0, "activated_o after reset");
  check_word(bus_word_t'(eng_req.rstn), '0, "unit reset released too early");
  check_word(bus_word_t'(eng_req.empty), 32'd1, "eng_req_o.empty after reset");
endtask

task automatic test_control();
  bus_word_t v;
  bus_write(ADDR_CTRL, CTRL_ON);
  check_word(bus_word_t'(activated), 32'd1, "activated_o after enable");
  bus_read(ADDR_STATUS, v);
  check_word(v, ST_ACTIVE, "STATUS with global enable");
  bus_write(ADDR_HASH_CTRL, HCTRL_ON);
  wait_req_level("rstn", 1'b1);
  bus_read(ADDR_STATUS, v);
  check_word(v, ST_ACTIVE | ST_UNIT_ON, "STATUS with unit enabled");
  // soft reset, one low cycle on the unit reset
  bus_write(ADDR_HASH_CTRL, HCTRL_ON | HCTRL_RST);
  wait_req_level("rstn", 1'b0);
  wait_req_level("rstn", 1'b1);
  bus_read(ADDR_HASH_CTRL, v);
  check_word(v, HCTRL_ON, "HASH_CTRL reset bit not self cleared");
  bus_write(ADDR_CTRL, '0);
  check_word(bus_word_t'(activated), '0, "activated_o after disable");
  wait_req_level("rstn", 1'b0);
  bus_read(ADDR_STATUS, v);
  check_word(v, '0, "STATUS after global disable");
endtask

task automatic test_fifo_push_pop();
  bus_word_t v;
  model_pop   = 1'b0;  // engine paused
  model_ready = 1'b0;
  popped.delete();
  pushed.delete();
  enable_unit();
  push_words(5, 32'h3000_0000);
  wait_fill(5);
  bus_read(ADDR_FIFO_PUSH, v);
  check_word(v, 32'd5, "fill level at FIFO_PUSH");
  bus_read(ADDR_HASH_STATUS, v);
  check_word(v & HST_EMPTY, '0, "empty with words queued");
  check_word(bus_word_t'(eng_req.empty), '0, "eng_req_o.empty with words queued");
  model_pop = 1'b1;
  wait_popped(5);
  for (int i = 0; i < 5; i++) begin
    check_word(popped[i], pushed[i], $sformatf("popped word %0d", i));
  end
  bus_read(ADDR_HASH_STATUS, v);
  check_word(v & HST_EMPTY, HST_EMPTY, "empty after drain");
  check_word(bus_word_t'(eng_req.empty), 32'd1, "eng_req_o.empty after drain");
  model_pop = 1'b0;
endtask

task automatic test_fifo_overflow();
  bus_word_t v;
  popped.delete();
  pushed.delete();
  push_words(FIFO_DEPTH + 3, 32'h4000_0000);
  wait_fill(FIFO_DEPTH);
  bus_read(ADDR_FIFO_PUSH, v);
  check_word(v, FIFO_DEPTH, "fill level after overflow");
  bus_read(ADDR_HASH_STATUS, v);
  check_word(v & (HST_FULL | HST_AFULL | HST_EMPTY), HST_FULL, "flags when full");
  model_pop = 1'b1;
  wait_popped(FIFO_DEPTH);
  for (int i = 0; i < FIFO_DEPTH; i++) begin
    check_word(popped[i], pushed[i], $sformatf("drained word %0d", i));
  end
  bus_read(ADDR_HASH_STATUS, v);
  check_word(v & HST_EMPTY, HST_EMPTY, "empty after overflow drain");
  check_word(popped.size(), FIFO_DEPTH, "dropped words reached the engine");
  model_pop = 1'b0;
endtask

task automatic test_hash_capture();
  bus_word_t v;
  popped.delete();
  pushed.delete();
  start_cnt   = 0;
  model_ready = 1'b1;
  model_pop   = 1'b1;
  push_words(1, 32'h5000_0000);
  wait_start();
  bus_read(ADDR_HASH_STATUS, v);
  check_word(v & (HST_VALID | HST_READY), HST_VALID | HST_READY, "hash_valid status");
  // H0 at the top address holds the most significant word
  for (int i = 0; i < HASH_WORDS; i++) begin
    bus_read(bus_addr_t'(ADDR_HASH_H0 - 4*i), v);
    check_word(v, model_hash[(HASH_WORDS-1-i)*32 +: 32], $sformatf("hash word H%0d", i));
  end
  // one word queued, so one start only
  check_word(start_cnt, 32'd1, "start pulses for a single queued word");
  bus_write(ADDR_HASH_CTRL, HCTRL_ON | HCTRL_RST);
  wait_req_level("rstn", 1'b0);
  wait_req_level("rstn", 1'b1);
  for (int i = 0; i < HASH_WORDS; i++) begin
    bus_read(bus_addr_t'(ADDR_HASH_H0 - 4*i), v);
    check_word(v, '0, $sformatf("hash word H%0d after soft reset", i));
  end
  model_ready = 1'b0;
  model_pop   = 1'b0;
endtask

task automatic test_dbl_hash();
  bus_word_t v;
  bus_write(ADDR_HASH_CTRL, HCTRL_ON | HCTRL_DBL);
  wait_req_level("dbl", 1'b1);
  bus_read(ADDR_HASH_CTRL, v);
  check_word(v, HCTRL_ON | HCTRL_DBL, "HASH_CTRL with double hash");
  bus_write(ADDR_HASH_CTRL, HCTRL_DBL);  // unit off, bit kept
  wait_req_level("dbl", 1'b0);
  check_word(bus_word_t'(eng_req.rstn), '0, "unit still out of reset");
endtask

// ==== testbench/tb_hash_accel_regs.sv ====
module tb_hash_accel_regs
  import accel_regs_pkg::*;
  import hash_pkg::*;
();

  // --------------------
  // timing
  // --------------------

  localparam int CLK_HALF   = 50;    // 100 unit period
  localparam int RST_CYCLES = 4;
  localparam int DRV_DLY    = 10;    // bus side drives after the edge
  localparam int MODEL_DLY  = 5;     // engine model acts before the bus side
  localparam int WAIT_LIMIT = 2000;  // cycles per wait loop

  // register values as the map defines them
  localparam bus_word_t CTRL_ON    = bus_word_t'(1) << CTRL_ENABLE;
  localparam bus_word_t HCTRL_ON   = bus_word_t'(1) << HCTRL_ENABLE;
  localparam bus_word_t HCTRL_RST  = bus_word_t'(1) << HCTRL_RESET;
  localparam bus_word_t HCTRL_DBL  = bus_word_t'(1) << HCTRL_DBL_HASH;
  localparam bus_word_t ST_ACTIVE  = 32'h0000_0001;  // global enable
  localparam bus_word_t ST_UNIT_ON = 32'h0000_0010;  // unit out of reset
  localparam bus_word_t HST_READY  = 32'h0000_0001;
  localparam bus_word_t HST_VALID  = 32'h0000_0002;
  localparam bus_word_t HST_EMPTY  = 32'h0000_0010;
  localparam bus_word_t HST_AFULL  = 32'h0000_0020;
  localparam bus_word_t HST_FULL   = 32'h0000_0040;

  logic     bus_clk;
  logic     bus_rstn;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  eng_req_t eng_req;
  eng_rsp_t eng_rsp;
  logic     activated;

  // engine model state
  logic       model_pop;    // pop words while the fifo has any
  logic       model_ready;  // ready level towards the unit
  int         start_cnt;
  hash_t      model_hash;
  integer     seed;
  data_word_t popped [$];   // words as the core received them
  data_word_t pushed [$];   // words the bus pushed and the fifo kept

  hash_accel_regs UUT (
    .bus_clk     (bus_clk),
    .bus_rstn    (bus_rstn),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .eng_rsp_i   (eng_rsp),
    .eng_req_o   (eng_req),
    .activated_o (activated)
  );

  initial begin
    bus_clk = 1'b0;
    forever #CLK_HALF bus_clk = ~bus_clk;
  end

  // --------------------
  // engine model
  // --------------------

  always @(posedge bus_clk) begin
    #MODEL_DLY;
    if (!eng_req.rstn) begin
      eng_rsp.hash_valid = 1'b0;  // core held in reset
      eng_rsp.rd_en      = 1'b0;
    end else begin
      if (eng_req.rd_vld) popped.push_back(eng_req.rd_data);
      if (eng_req.start) begin
        start_cnt++;
        // a new hash only once the previous one was dropped
        if (!eng_rsp.hash_valid) begin
          for (int i = 0; i < HASH_WORDS; i++) begin
            model_hash[i*32 +: 32] = $random(seed);
          end
          eng_rsp.hash       = model_hash;
          eng_rsp.hash_valid = 1'b1;
        end
      end
      eng_rsp.rd_en = model_pop && !eng_req.empty;  // one pop per cycle
    end
    eng_rsp.ready = model_ready;
  end

  // stops the run at the first error
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  `include "tb_tasks.svh"

  // --------------------
  // test sequence
  // --------------------

  initial begin
    bus_rstn    = 1'b0;
    bus_req     = '0;
    eng_rsp     = '0;
    model_pop   = 1'b0;
    model_ready = 1'b0;
    start_cnt   = 0;
    model_hash  = '0;
    seed        = 54;
    repeat (RST_CYCLES) @(posedge bus_clk);
    #DRV_DLY;
    bus_rstn = 1'b1;

    test_reset_version();
    test_control();
    test_fifo_push_pop();
    test_fifo_overflow();
    test_hash_capture();
    test_dbl_hash();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== hash_accel_regs.f ====
+incdir+testbench
logic/accel_regs_pkg.sv
logic/hash_pkg.sv
logic/bus_regs.sv
logic/hash_unit_ctrl.sv
logic/word_fifo.sv
logic/hash_accel_regs.sv
testbench/tb_hash_accel_regs.sv

// ==== Bender.yml ====
package:
  name: hash_accel_regs

sources:
  # packages first, then leaf modules, then the top level
  - logic/accel_regs_pkg.sv
  - logic/hash_pkg.sv
  - logic/bus_regs.sv
  - logic/hash_unit_ctrl.sv
  - logic/word_fifo.sv
  - logic/hash_accel_regs.sv

  # testbench, top module tb_hash_accel_regs
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_hash_accel_regs.sv
